/* Bender.yml */
package:
  name: pep_ntt_slice

sources:
  - files:
      - logic/pep_param_pkg.sv
      - logic/pep_stream_pkg.sv
      - logic/pep_modsw.sv
      - logic/pep_elt_fifo.sv
      - logic/pep_decomp.sv
      - logic/pep_ntt_slice.sv
  - target: simulation
    files:
      - sim/pep_ntt_slice_assert.sv
      - sim/tb_pep_ntt_slice.sv

/* logic/pep_decomp.sv */
`default_nettype none
// ---------------------------------------------------------------------
// Balanced decomposition
// Splits each buffered element into PBS_L signed digits of base
// 2^PBS_B_W, least significant level first, one digit per cycle
// ---------------------------------------------------------------------

module pep_decomp (
  input  logic                        prc_clk,
  input  logic                        prc_srst_n,

  input  pep_stream_pkg::modsw_elt_t  head_elt,
  input  logic                        head_vld,

  output logic                        pop,
  output pep_stream_pkg::decomp_elt_t out_elt,
  output logic                        out_avail,
  output logic                        digit_inc
);

  localparam int B_W = pep_param_pkg::PBS_B_W;

  pep_stream_pkg::modsw_elt_t          cur;
  logic                                busy;
  logic [pep_param_pkg::LEVEL_W-1:0]   level;
  logic [B_W-1:0]                      low;
  logic                                carry;
  logic                                last_lvl;
  logic [pep_param_pkg::MODSW_W-1:0]   res_next;

  // Low bits of the residual, carry when at least half the base
  assign low   = cur.data[B_W-1:0];
  assign carry = low[B_W-1];

  // Carry is folded into the residual; beyond the last level it is lost
  assign res_next = (cur.data >> B_W) + pep_param_pkg::MODSW_W'(carry);

  assign last_lvl = busy & (level == pep_param_pkg::LEVEL_W'(pep_param_pkg::PBS_L - 1));

  // Next element taken while idle or on the last digit
  assign pop = head_vld & (~busy | last_lvl);

  // ---------------------------------------------------------------------
  // Level control
  // ---------------------------------------------------------------------
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      busy      <= 1'b0;
      level     <= '0;
      out_avail <= 1'b0;
    end else begin
      out_avail <= busy;
      if (pop) begin
        busy  <= 1'b1;
        level <= '0;
      end else if (last_lvl) begin
        busy <= 1'b0;
      end else if (busy) begin
        level <= level + 1'b1;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Residual and digit output
  // ---------------------------------------------------------------------
  always_ff @(posedge prc_clk) begin
    if (pop) begin
      cur <= head_elt;
    end else if (busy) begin
      cur.data <= res_next;
    end

    // low - 2^B when carry, which is just {carry, low} in B+1 bits
    out_elt.digit  <= $signed({carry, low});
    out_elt.level  <= level;
    out_elt.pbs_id <= cur.pbs_id;
    out_elt.sob    <= cur.sob & (level == '0);
    out_elt.eob    <= cur.eob & last_lvl;
  end

  // One count per emitted digit
  assign digit_inc = out_avail;

endmodule

`default_nettype wire

/* logic/pep_elt_fifo.sv */
`default_nettype none
// ---------------------------------------------------------------------
// Element buffer
// Circular FIFO between the modulus switch and the decomposer,
// a push into a full buffer is dropped and flagged
// ---------------------------------------------------------------------

module pep_elt_fifo #(
  parameter int FIFO_DEPTH = pep_param_pkg::FIFO_DEPTH_DFLT
) (
  input  logic                       prc_clk,
  input  logic                       prc_srst_n,

  input  pep_stream_pkg::modsw_elt_t sw_elt,
  input  logic                       sw_avail,
  input  logic                       pop,

  output pep_stream_pkg::modsw_elt_t head_elt,
  output logic                       head_vld,
  output logic                       fifo_ovf
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  pep_stream_pkg::modsw_elt_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push_ok;
  logic             pop_ok;

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign push_ok = sw_avail & ~full;
  assign pop_ok  = pop & head_vld;

  // ---------------------------------------------------------------------
  // Pointers and occupancy
  // ---------------------------------------------------------------------
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      fifo_ovf <= 1'b0;
    end else begin
      fifo_ovf <= sw_avail & full;
      if (push_ok) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge prc_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= sw_elt;
    end
  end

  // Head is read straight from storage
  assign head_elt = mem[rd_ptr];
  assign head_vld = (count != '0);

endmodule

`default_nettype wire

/* logic/pep_modsw.sv */
`default_nettype none
// ---------------------------------------------------------------------
// Modulus switch
// Decodes header and coefficient words, tracks the batch id and
// rounds each coefficient to its top MODSW_W bits
// ---------------------------------------------------------------------

module pep_modsw (
  input  logic                       prc_clk,
  input  logic                       prc_srst_n,

  input  pep_stream_pkg::proc_word_u in_word,
  input  logic                       in_avail,
  input  logic                       in_hdr,
  input  logic                       in_last,

  output pep_stream_pkg::modsw_elt_t sw_elt,
  output logic                       sw_avail,
  output logic                       coef_inc
);

  // Number of dropped low bits
  localparam int DROP_W = pep_param_pkg::MOD_Q_W - pep_param_pkg::MODSW_W;

  // Half of the least significant kept unit
  localparam logic [pep_param_pkg::MOD_Q_W-1:0] ROUND_HALF =
    pep_param_pkg::MOD_Q_W'(1) << (DROP_W - 1);

  logic                                hdr_vld;
  logic                                coef_vld;
  logic [pep_param_pkg::BPBS_ID_W-1:0] cur_pbs_id;
  logic                                sob_pend;
  logic [pep_param_pkg::MOD_Q_W-1:0]   coef_rnd;

  assign hdr_vld  = in_avail & in_hdr;
  assign coef_vld = in_avail & ~in_hdr;

  // Wraps modulo 2^MOD_Q_W, so the kept bits wrap modulo 2^MODSW_W
  assign coef_rnd = in_word.coef + ROUND_HALF;

  // ---------------------------------------------------------------------
  // Batch tracking
  // ---------------------------------------------------------------------
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      cur_pbs_id <= '0;
      sob_pend   <= 1'b0;
      sw_avail   <= 1'b0;
    end else begin
      sw_avail <= coef_vld;
      if (hdr_vld) begin
        cur_pbs_id <= in_word.hdr.pbs_id;
        sob_pend   <= 1'b1;
      end else if (coef_vld) begin
        sob_pend <= 1'b0;
      end
    end
  end

  // ---------------------------------------------------------------------
  // Switched element
  // ---------------------------------------------------------------------
  always_ff @(posedge prc_clk) begin
    if (coef_vld) begin
      sw_elt.data   <= coef_rnd[pep_param_pkg::MOD_Q_W-1 -: pep_param_pkg::MODSW_W];
      sw_elt.pbs_id <= cur_pbs_id;
      sw_elt.sob    <= sob_pend;
      sw_elt.eob    <= in_last;
    end
  end

  // One count per switched element
  assign coef_inc = sw_avail;

endmodule

`default_nettype wire

/* logic/pep_ntt_slice.sv */
`default_nettype none
// ---------------------------------------------------------------------
// PBS processing slice top level
// Modulus switch, element buffer and balanced decomposer in a row,
// with the error and counter side word
// ---------------------------------------------------------------------

module pep_ntt_slice #(
  parameter int FIFO_DEPTH = pep_param_pkg::FIFO_DEPTH_DFLT
) (
  input  logic                        prc_clk,
  input  logic                        prc_srst_n,

  input  pep_stream_pkg::proc_word_u  in_word,
  input  logic                        in_avail,
  input  logic                        in_hdr,
  input  logic                        in_last,

  output pep_stream_pkg::decomp_elt_t out_elt,
  output logic                        out_avail,
  output pep_stream_pkg::pep_side_t   side
);

  // Switch to buffer
  pep_stream_pkg::modsw_elt_t sw_elt;
  logic                       sw_avail;

  // Buffer to decomposer
  pep_stream_pkg::modsw_elt_t head_elt;
  logic                       head_vld;
  logic                       pop;

  // Side fields
  logic                       coef_inc;
  logic                       digit_inc;
  logic                       fifo_ovf;

  pep_modsw modsw0 (
    .prc_clk    (prc_clk),
    .prc_srst_n (prc_srst_n),
    .in_word    (in_word),
    .in_avail   (in_avail),
    .in_hdr     (in_hdr),
    .in_last    (in_last),
    .sw_elt     (sw_elt),
    .sw_avail   (sw_avail),
    .coef_inc   (coef_inc)
  );

  pep_elt_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .prc_clk    (prc_clk),
    .prc_srst_n (prc_srst_n),
    .sw_elt     (sw_elt),
    .sw_avail   (sw_avail),
    .pop        (pop),
    .head_elt   (head_elt),
    .head_vld   (head_vld),
    .fifo_ovf   (fifo_ovf)
  );

  pep_decomp decomp0 (
    .prc_clk    (prc_clk),
    .prc_srst_n (prc_srst_n),
    .head_elt   (head_elt),
    .head_vld   (head_vld),
    .pop        (pop),
    .out_elt    (out_elt),
    .out_avail  (out_avail),
    .digit_inc  (digit_inc)
  );

  // Side word, every field already a flop output
  assign side.error.fifo_ovf        = fifo_ovf;
  assign side.counter_inc.coef_in   = coef_inc;
  assign side.counter_inc.digit_out = digit_inc;

endmodule

`default_nettype wire

/* logic/pep_param_pkg.sv */
`default_nettype none
// ---------------------------------------------------------------------
// PBS processing slice parameters
// Width and count constants shared by the switch, buffer and
// decomposition stages
// ---------------------------------------------------------------------

package pep_param_pkg;

  // Incoming coefficient width, modulus 2^MOD_Q_W
  localparam int MOD_Q_W = 32;

  // Width after modulus switch
  localparam int MODSW_W = 12;

  // Decomposition base log and number of levels
  // MODSW_W is PBS_B_W * PBS_L
  localparam int PBS_B_W = 4;
  localparam int PBS_L   = 3;

  // Enough bits to index PBS_L levels
  localparam int LEVEL_W = 2;

  // Batch identifier
  localparam int BPBS_ID_W = 6;

  // Element buffer depth when the top level does not override it
  localparam int FIFO_DEPTH_DFLT = 4;

endpackage

`default_nettype wire

/* logic/pep_stream_pkg.sv */
`default_nettype none
// ---------------------------------------------------------------------
// PBS processing slice stream types
// Input word, switched element, output digit and side word layouts
// ---------------------------------------------------------------------

package pep_stream_pkg;

  // ------------------------------------------------------------------
  // Input side
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [pep_param_pkg::BPBS_ID_W-1:0]                        pbs_id;
    logic [pep_param_pkg::MOD_Q_W-pep_param_pkg::BPBS_ID_W-1:0] reserved;
  } hdr_t;

  // Same 32-bit word, in_hdr tells which view applies
  typedef union packed {
    logic [pep_param_pkg::MOD_Q_W-1:0] coef;
    hdr_t                              hdr;
  } proc_word_u;

  // ------------------------------------------------------------------
  // Switched element, as stored in the buffer
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [pep_param_pkg::MODSW_W-1:0]   data;
    logic [pep_param_pkg::BPBS_ID_W-1:0] pbs_id;
    logic                                sob;
    logic                                eob;
  } modsw_elt_t;

  // ------------------------------------------------------------------
  // Output digit
  // ------------------------------------------------------------------
  typedef struct packed {
    // Two's complement, one bit wider than the base
    logic signed [pep_param_pkg::PBS_B_W:0] digit;
    logic [pep_param_pkg::LEVEL_W-1:0]      level;
    logic [pep_param_pkg::BPBS_ID_W-1:0]    pbs_id;
    logic                                   sob;
    logic                                   eob;
  } decomp_elt_t;

  // ------------------------------------------------------------------
  // Side word
  // ------------------------------------------------------------------
  typedef struct packed {
    logic fifo_ovf;
  } pep_error_t;

  typedef struct packed {
    logic coef_in;
    logic digit_out;
  } pep_counter_inc_t;

  typedef struct packed {
    pep_error_t       error;
    pep_counter_inc_t counter_inc;
  } pep_side_t;

endpackage

`default_nettype wire

/* pep_ntt_slice.f */
logic/pep_param_pkg.sv
logic/pep_stream_pkg.sv
logic/pep_modsw.sv
logic/pep_elt_fifo.sv
logic/pep_decomp.sv
logic/pep_ntt_slice.sv
sim/pep_ntt_slice_assert.sv
sim/tb_pep_ntt_slice.sv

/* sim/pep_golden.txt */
// kind (1 header, 2 coef, 3 coef last, 0 end), word, idle gap,
// switched value, digits level 0..2 as two's complement bytes
1 14000000 2 000 00 00 00
2 12345678 1 123 03 02 01
2 abcdef01 3 abd fd fc fb
3 7ff80000 2 800 00 00 f8
// second batch
1 a8000123 1 000 00 00 00
2 ffffffff 2 000 00 00 00
2 00088000 1 001 01 00 00
2 0f7fffff 4 0f8 f8 00 01
3 fff00000 3 fff ff 00 00
// burst, back to back
1 fc000000 3 000 00 00 00
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
2 55555555 0 555 05 05 05
0 00000000 0 000 00 00 00

/* sim/pep_ntt_slice_assert.sv */
`default_nettype none
// ----------------------------------------------------------------------
// Slice output assertions
// Reset quiet output, digit range and level order
// ----------------------------------------------------------------------

module pep_ntt_slice_assert (
  input logic                        prc_clk,
  input logic                        prc_srst_n,
  input pep_stream_pkg::decomp_elt_t out_elt,
  input logic                        out_avail
);

  localparam int L    = pep_param_pkg::PBS_L;
  localparam int HALF = 1 << (pep_param_pkg::PBS_B_W - 1);

  logic [pep_param_pkg::LEVEL_W-1:0] prev_lvl;
  logic [pep_param_pkg::LEVEL_W-1:0] next_lvl;

  // Failed assertion count
  int n_fail = 0;

  // Last digit level seen, reset to the level before 0
  always_ff @(posedge prc_clk) begin
    if (!prc_srst_n) begin
      prev_lvl <= pep_param_pkg::LEVEL_W'(L - 1);
    end else if (out_avail) begin
      prev_lvl <= out_elt.level;
    end
  end

  assign next_lvl = (prev_lvl == pep_param_pkg::LEVEL_W'(L - 1)) ? '0 : prev_lvl + 1'b1;

  // Synchronous reset clears out_avail on the edge that sees it
  a_reset_quiet : assert property (@(posedge prc_clk) !prc_srst_n |=> !out_avail)
    else begin
      n_fail++;
      $error("out_avail high in reset");
    end

  a_digit_range : assert property (@(posedge prc_clk) disable iff (!prc_srst_n)
    out_avail |-> (int'(out_elt.digit) >= -HALF && int'(out_elt.digit) <= HALF))
    else begin
      n_fail++;
      $error("digit out of balanced range");
    end

  a_level_order : assert property (@(posedge prc_clk) disable iff (!prc_srst_n)
    out_avail |-> out_elt.level == next_lvl)
    else begin
      n_fail++;
      $error("level out of order");
    end

endmodule

bind pep_ntt_slice pep_ntt_slice_assert assert0 (
  .prc_clk    (prc_clk),
  .prc_srst_n (prc_srst_n),
  .out_elt    (out_elt),
  .out_avail  (out_avail)
);

`default_nettype wire

/* sim/tb_pep_ntt_slice.sv */
`default_nettype none
// ----------------------------------------------------------------------
// PBS processing slice testbench
// Replays golden input records, checks every output digit, the
// reconstruction of each element, batch flags and overflow counts
// ----------------------------------------------------------------------

module tb_pep_ntt_slice;

  localparam int L       = pep_param_pkg::PBS_L;
  localparam int B_W     = pep_param_pkg::PBS_B_W;
  localparam int REC_W   = 7;
  localparam int MAX_REC = 64;

  // Expected element, built from the golden record and batch rules
  typedef struct packed {
    logic [pep_param_pkg::MODSW_W-1:0]   data;
    logic [L-1:0][B_W:0]                 digs;
    logic [pep_param_pkg::BPBS_ID_W-1:0] pbs_id;
    logic                                sob;
    logic                                eob;
  } exp_elt_t;

  logic                               prc_clk;
  logic                               prc_srst_n;
  pep_stream_pkg::proc_word_u         in_word;
  logic                               in_avail;
  logic                               in_hdr;
  logic                               in_last;
  pep_stream_pkg::decomp_elt_t        out_elt;
  logic                               out_avail;
  pep_stream_pkg::pep_side_t          side;

  logic [31:0] gold [0:REC_W*MAX_REC-1];
  exp_elt_t    exp_q [$];

  int err_mismatch;
  int err_other;
  int err_assert;
  int n_coef;
  int n_ovf;
  int n_dig;
  int n_dig_inc;
  int n_sent;
  int lvl_cnt;
  int recon;

  pep_ntt_slice #(
    .FIFO_DEPTH (4)
  ) dut0 (
    .prc_clk    (prc_clk),
    .prc_srst_n (prc_srst_n),
    .in_word    (in_word),
    .in_avail   (in_avail),
    .in_hdr     (in_hdr),
    .in_last    (in_last),
    .out_elt    (out_elt),
    .out_avail  (out_avail),
    .side       (side)
  );

  initial begin
    prc_clk = 1'b0;
    forever begin
      #50 prc_clk = ~prc_clk;
    end
  end

  // Round to the top bits, half a kept unit added first
  function automatic logic [pep_param_pkg::MODSW_W-1:0] round_coef(input logic [31:0] w);
    logic [31:0] t;
    t = w + (32'd1 << (pep_param_pkg::MOD_Q_W - pep_param_pkg::MODSW_W - 1));
    return t[31 -: pep_param_pkg::MODSW_W];
  endfunction

  // ----------------------------------------------------------------------
  // Output monitor, sampled on the falling edge
  // ----------------------------------------------------------------------
  always @(negedge prc_clk) begin
    if (prc_srst_n) begin
      if (side.counter_inc.coef_in) n_coef++;
      if (side.error.fifo_ovf) n_ovf++;
      if (side.counter_inc.digit_out) n_dig_inc++;
      if (out_avail) begin
        n_dig++;
        if (exp_q.size() == 0) begin
          err_other++;
          $display("Digit came out with no element expected");
        end else begin
          if (out_elt.level != lvl_cnt) begin
            err_mismatch++;
            $display("MISMATCH level: expected %0d actual %0d", lvl_cnt, out_elt.level);
          end
          if (out_elt.digit != $signed(exp_q[0].digs[lvl_cnt])) begin
            err_mismatch++;
            $display("MISMATCH digit: expected %0d actual %0d",
                     $signed(exp_q[0].digs[lvl_cnt]), out_elt.digit);
          end
          if (out_elt.pbs_id != exp_q[0].pbs_id) begin
            err_mismatch++;
            $display("MISMATCH pbs_id: expected %0d actual %0d",
                     exp_q[0].pbs_id, out_elt.pbs_id);
          end
          if (out_elt.sob != (exp_q[0].sob && lvl_cnt == 0)) begin
            err_mismatch++;
            $display("MISMATCH sob: expected %0b actual %0b",
                     exp_q[0].sob && lvl_cnt == 0, out_elt.sob);
          end
          if (out_elt.eob != (exp_q[0].eob && lvl_cnt == L - 1)) begin
            err_mismatch++;
            $display("MISMATCH eob: expected %0b actual %0b",
                     exp_q[0].eob && lvl_cnt == L - 1, out_elt.eob);
          end
          recon = recon + int'(out_elt.digit) * (1 << (B_W * lvl_cnt));
          if (lvl_cnt == L - 1) begin
            if (pep_param_pkg::MODSW_W'(recon) != exp_q[0].data) begin
              err_mismatch++;
              $display("MISMATCH recon: expected %03h actual %03h",
                       exp_q[0].data, pep_param_pkg::MODSW_W'(recon));
            end
            void'(exp_q.pop_front());
            lvl_cnt = 0;
            recon   = 0;
          end else begin
            lvl_cnt++;
          end
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    int       rec;
    int       kind;
    int       gap;
    int       wait_cnt;
    logic [5:0] cur_id;
    logic     sob_pend;
    exp_elt_t e;

    void'($urandom(32'h922aee94));
    err_mismatch = 0;
    err_other    = 0;
    err_assert   = 0;
    n_coef       = 0;
    n_ovf        = 0;
    n_dig        = 0;
    n_dig_inc    = 0;
    n_sent       = 0;
    lvl_cnt      = 0;
    recon        = 0;
    cur_id       = '0;
    sob_pend     = 1'b0;
    prc_srst_n   = 1'b0;
    in_word      = '0;
    in_avail     = 1'b0;
    in_hdr       = 1'b0;
    in_last      = 1'b0;
    $readmemh("sim/pep_golden.txt", gold);

    repeat (10) @(posedge prc_clk);
    prc_srst_n <= 1'b1;

    // Quiet outputs before any input
    repeat (5) begin
      @(negedge prc_clk);
      if (out_avail !== 1'b0 || side !== '0) begin
        err_other++;
        $display("Output or side bit active before the first input");
      end
    end

    rec  = 0;
    kind = int'(gold[0]);
    while (kind != 0 && rec < MAX_REC) begin
      gap = int'(gold[rec*REC_W + 2]);
      @(posedge prc_clk);
      in_word  <= gold[rec*REC_W + 1];
      in_avail <= 1'b1;
      in_hdr   <= (kind == 1);
      in_last  <= (kind == 3);
      if (kind == 1) begin
        cur_id   = gold[rec*REC_W + 1][31:26];
        sob_pend = 1'b1;
      end else begin
        e.data   = gold[rec*REC_W + 3][pep_param_pkg::MODSW_W-1:0];
        for (int i = 0; i < L; i++) begin
          e.digs[i] = gold[rec*REC_W + 4 + i][B_W:0];
        end
        e.pbs_id = cur_id;
        e.sob    = sob_pend;
        e.eob    = (kind == 3);
        sob_pend = 1'b0;
        if (round_coef(gold[rec*REC_W + 1]) != e.data) begin
          err_other++;
          $display("Golden record %0d has a switched value off the rounding rule", rec);
        end
        exp_q.push_back(e);
        n_sent++;
      end
      if (gap != 0) begin
        gap = gap + L + int'($urandom % 3);
      end
      repeat (gap) begin
        @(posedge prc_clk);
        in_avail <= 1'b0;
      end
      rec++;
      kind = int'(gold[rec*REC_W]);
    end
    @(posedge prc_clk);
    in_avail <= 1'b0;

    // Drain until only dropped elements remain
    wait_cnt = 0;
    while (exp_q.size() > n_ovf && wait_cnt < 500) begin
      @(negedge prc_clk);
      wait_cnt++;
    end
    if (wait_cnt >= 500) begin
      err_other++;
      $display("Timed out waiting for the slice to drain");
    end
    repeat (5) @(negedge prc_clk);

    if (n_ovf < 1) begin
      err_other++;
      $display("Burst did not overflow the buffer");
    end
    if (n_coef != n_sent) begin
      err_other++;
      $display("Coefficient count %0d differs from %0d sent", n_coef, n_sent);
    end
    if (n_dig != L * (n_coef - n_ovf)) begin
      err_other++;
      $display("Digit count %0d does not match accepted elements", n_dig);
    end
    if (n_dig_inc != n_dig) begin
      err_other++;
      $display("digit_out pulses %0d differ from %0d digits", n_dig_inc, n_dig);
    end
    if (exp_q.size() != n_ovf) begin
      err_other++;
      $display("%0d elements left over for %0d drops", exp_q.size(), n_ovf);
    end

    // Bound assertion failures
    err_assert = dut0.assert0.n_fail;

    $display("Errors: %0d mismatch, %0d other, %0d assertion",
             err_mismatch, err_other, err_assert);
    if (err_mismatch == 0 && err_other == 0 && err_assert == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
